// File: verilog/fpu_div_settings.svh
`ifndef FPU_DIV_SETTINGS_SVH
`define FPU_DIV_SETTINGS_SVH

// mantissa with hidden bit.
`define FPU_MAN_W	24

// signed exponent inside the datapath.
`define FPU_EXP_W	10

`define FPU_EXP_BIAS	127
`define FPU_EXP_MAX	255

// two quotient bits per step.
`define FPU_DIV_STEPS	13

`endif

// File: verilog/fpu_div_pkg.sv
package fpu_div_pkg;

	// binary32 field layout.
	typedef struct packed {
		logic		sign;
		logic	[7:0]	exponent;
		logic	[22:0]	fraction;
	} float32_fields;

	// raw word or its fields.
	typedef union packed {
		logic	[31:0]	bits;
		float32_fields	f;
	} float32_word;

	typedef enum logic [2:0] {
		rne	= 3'd0,	// nearest with ties to even.
		rtz	= 3'd1,
		rdn	= 3'd2,
		rup	= 3'd3,
		rmm	= 3'd4	// nearest with ties away.
	} round_mode_t;

	// flag vector is {nv, dz, of, uf, nx}.
	localparam int unsigned flag_w	= 5;
	localparam int unsigned flag_nv	= 4;
	localparam int unsigned flag_dz	= 3;
	localparam int unsigned flag_of	= 2;
	localparam int unsigned flag_uf	= 1;
	localparam int unsigned flag_nx	= 0;

endpackage

// File: verilog/operand_unpack.sv
`timescale 1ns/1ns
`include "fpu_div_settings.svh"

module operand_unpack import fpu_div_pkg::*; (
	input	logic			clk,
	input	logic			reset,

	input	logic			in_valid,
	output	logic			in_ready,
	input	float32_word		a,
	input	float32_word		b,
	input	round_mode_t		rm,

	output	logic			out_valid,
	input	logic			out_ready,

	output	logic	[`FPU_MAN_W-1:0]	man_a,
	output	logic	[`FPU_EXP_W-1:0]	exp_a,
	output	logic			sgn_a,
	output	logic			zero_a,
	output	logic			inf_a,
	output	logic			snan_a,
	output	logic			qnan_a,

	output	logic	[`FPU_MAN_W-1:0]	man_b,
	output	logic	[`FPU_EXP_W-1:0]	exp_b,
	output	logic			sgn_b,
	output	logic			zero_b,
	output	logic			inf_b,
	output	logic			snan_b,
	output	logic			qnan_b,

	output	round_mode_t		rm_out
);

	// {zero, inf, snan, qnan}; subnormals land in zero.
	function automatic logic [3:0] classify(input float32_word w);
		logic	exp_ones;
		logic	frac_zero;
		exp_ones	= (w.f.exponent == 8'(`FPU_EXP_MAX));
		frac_zero	= (w.f.fraction == '0);
		classify	= {w.f.exponent == '0,
				   exp_ones && frac_zero,
				   exp_ones && !frac_zero && !w.f.fraction[22],
				   exp_ones && !frac_zero && w.f.fraction[22]};
	endfunction

	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// payload slot.
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			man_a	<= {1'b1, a.f.fraction};
			exp_a	<= `FPU_EXP_W'(a.f.exponent);
			sgn_a	<= a.f.sign;
			{zero_a, inf_a, snan_a, qnan_a} <= classify(a);
			man_b	<= {1'b1, b.f.fraction};
			exp_b	<= `FPU_EXP_W'(b.f.exponent);
			sgn_b	<= b.f.sign;
			{zero_b, inf_b, snan_b, qnan_b} <= classify(b);
			rm_out	<= rm;
		end
	end

endmodule

// File: verilog/float_divider.sv
`timescale 1ns/1ns
`include "fpu_div_settings.svh"

module float_divider import fpu_div_pkg::*; (
	input	logic			clk,
	input	logic			reset,

	input	logic			valid_in,
	output	logic			ready_out,
	output	logic			valid_out,
	input	logic			ready_in,

	input	round_mode_t		rm,

	input	logic	[`FPU_MAN_W-1:0]	man_a,
	input	logic	[`FPU_EXP_W-1:0]	exp_a,
	input	logic			sgn_a,
	input	logic			zero_a,
	input	logic			inf_a,
	input	logic			snan_a,
	input	logic			qnan_a,

	input	logic	[`FPU_MAN_W-1:0]	man_b,
	input	logic	[`FPU_EXP_W-1:0]	exp_b,
	input	logic			sgn_b,
	input	logic			zero_b,
	input	logic			inf_b,
	input	logic			snan_b,
	input	logic			qnan_b,

	output	logic	[`FPU_MAN_W-1:0]	man_y,
	output	logic	[`FPU_EXP_W-1:0]	exp_y,
	output	logic			sgn_y,

	output	logic			round_bit,
	output	logic			sticky_bit,
	output	logic			skip_round,

	output	logic			iv,
	output	logic			dz,

	output	round_mode_t		rm_out
);

	logic	[`FPU_MAN_W-1:0]	div_q;
	logic	[`FPU_MAN_W+1:0]	res_q;
	logic	[`FPU_MAN_W+2:0]	rem_q;
	logic	[`FPU_EXP_W-1:0]	exp_q;
	logic				sgn_q;
	logic	[3:0]			counter;

	logic				nan_case;
	logic				iv_d;

	logic	[`FPU_MAN_W+2:0]	div_ext;
	logic	[`FPU_MAN_W+2:0]	diff_1;
	logic	[`FPU_MAN_W+2:0]	diff_2;
	logic	[`FPU_MAN_W+2:0]	rem_1;
	logic	[`FPU_MAN_W+2:0]	rem_2;
	logic	[1:0]			q_bits;

	enum logic {st_idle, st_calc} state;

	assign nan_case	= snan_a || snan_b || qnan_a || qnan_b ||
			  (zero_a && zero_b) || (inf_a && inf_b);
	assign iv_d	= snan_a || snan_b || (zero_a && zero_b) || (inf_a && inf_b);

	// one division in flight; hand off only when the next stage can take it.
	assign ready_out = ready_in && (state == st_idle);

	// quotient is 1.x or 0.1x; shift by one in the second case.
	always_comb begin
		sgn_y = sgn_q;
		if (res_q[`FPU_MAN_W+1] || skip_round) begin
			exp_y		= exp_q;
			man_y		= res_q[`FPU_MAN_W+1:2];
			round_bit	= res_q[1];
			sticky_bit	= res_q[0] || (|rem_q);
		end else begin
			exp_y		= exp_q - `FPU_EXP_W'(1);
			man_y		= res_q[`FPU_MAN_W:1];
			round_bit	= res_q[0];
			sticky_bit	= |rem_q;
		end
	end

	// two restoring steps per cycle.
	always_comb begin
		div_ext		= {1'b0, div_q, 2'b00};
		diff_1		= rem_q - div_ext;
		q_bits[1]	= !diff_1[`FPU_MAN_W+2];
		rem_1		= (q_bits[1] ? diff_1 : rem_q) << 1;
		diff_2		= rem_1 - div_ext;
		q_bits[0]	= !diff_2[`FPU_MAN_W+2];
		rem_2		= (q_bits[0] ? diff_2 : rem_1) << 1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state		<= st_idle;
			counter		<= 4'd0;
			valid_out	<= 1'b0;
		end else if (valid_in && ready_out) begin
			div_q		<= man_b;
			rem_q		<= {1'b0, man_a, 2'b00};
			res_q		<= '0;
			exp_q		<= exp_a - exp_b;
			sgn_q		<= sgn_a ^ sgn_b;
			rm_out		<= rm;
			counter		<= 4'd0;
			iv		<= 1'b0;
			dz		<= 1'b0;
			skip_round	<= 1'b1;
			valid_out	<= 1'b1;
			if (nan_case) begin
				// canonical quiet NaN.
				res_q	<= {2'b11, {`FPU_MAN_W{1'b0}}};
				exp_q	<= `FPU_EXP_W'(`FPU_EXP_MAX);
				sgn_q	<= 1'b0;
				iv	<= iv_d;
			end else if (inf_a || zero_b) begin
				res_q	<= {1'b1, {(`FPU_MAN_W+1){1'b0}}};
				exp_q	<= `FPU_EXP_W'(`FPU_EXP_MAX);
				dz	<= zero_b && !inf_a;
			end else if (zero_a || inf_b) begin
				exp_q	<= '0;
			end else begin
				skip_round	<= 1'b0;
				valid_out	<= 1'b0;
				state		<= st_calc;
			end
		end else begin
			case (state)
				st_idle: begin
					if (valid_out && ready_in)
						valid_out <= 1'b0;
				end
				st_calc: begin
					res_q <= {res_q[`FPU_MAN_W-1:0], q_bits};
					rem_q <= rem_2;
					if (counter == 4'(`FPU_DIV_STEPS - 1)) begin
						valid_out	<= 1'b1;
						state		<= st_idle;
					end else begin
						counter <= counter + 4'd1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: verilog/round_pack.sv
`timescale 1ns/1ns
`include "fpu_div_settings.svh"

module round_pack import fpu_div_pkg::*; (
	input	logic			clk,
	input	logic			reset,

	input	logic			valid_in,
	output	logic			ready_out,

	input	logic	[`FPU_MAN_W-1:0]	man_y,
	input	logic	[`FPU_EXP_W-1:0]	exp_y,
	input	logic			sgn_y,
	input	logic			round_bit,
	input	logic			sticky_bit,
	input	logic			skip_round,
	input	logic			iv,
	input	logic			dz,
	input	round_mode_t		rm,

	output	logic			out_valid,
	input	logic			out_ready,
	output	float32_word		y,
	output	logic	[flag_w-1:0]	flags
);

	localparam logic signed [`FPU_EXP_W-1:0] exp_top = `FPU_EXP_W'(`FPU_EXP_MAX);

	logic				inexact;
	logic				inc;
	logic				to_max;
	logic	[`FPU_MAN_W:0]		man_r;
	logic signed [`FPU_EXP_W-1:0]	exp_b;
	logic	[22:0]			frac_r;
	float32_word			y_d;
	logic	[flag_w-1:0]		flags_d;

	always_comb begin
		inexact = round_bit || sticky_bit;
		case (rm)
			rne:	inc = round_bit && (sticky_bit || man_y[0]);
			rtz:	inc = 1'b0;
			rdn:	inc = inexact && sgn_y;
			rup:	inc = inexact && !sgn_y;
			rmm:	inc = round_bit;
			default: inc = 1'b0;
		endcase
		// modes that never round up in magnitude clamp to max finite.
		to_max	= (rm == rtz) || (rm == rdn && !sgn_y) || (rm == rup && sgn_y);
		man_r	= {1'b0, man_y} + {{`FPU_MAN_W{1'b0}}, inc};
		exp_b	= exp_y + `FPU_EXP_W'(`FPU_EXP_BIAS) + `FPU_EXP_W'(man_r[`FPU_MAN_W]);
		frac_r	= man_r[22:0];	// a carry leaves the fraction zero.

		y_d.bits	= '0;
		flags_d		= '0;
		y_d.f.sign	= sgn_y;
		if (skip_round) begin
			y_d.f.exponent	= exp_y[7:0];
			y_d.f.fraction	= man_y[22:0];
			flags_d[flag_nv] = iv;
			flags_d[flag_dz] = dz;
		end else if (exp_b >= exp_top) begin
			if (to_max) begin
				y_d.f.exponent	= 8'(`FPU_EXP_MAX - 1);
				y_d.f.fraction	= '1;
			end else begin
				y_d.f.exponent	= 8'(`FPU_EXP_MAX);
			end
			flags_d[flag_of] = 1'b1;
			flags_d[flag_nx] = 1'b1;
		end else if (exp_b[`FPU_EXP_W-1] || exp_b == '0) begin
			flags_d[flag_uf] = 1'b1;	// flushed to signed zero.
			flags_d[flag_nx] = 1'b1;
		end else begin
			y_d.f.exponent	= exp_b[7:0];
			y_d.f.fraction	= frac_r;
			flags_d[flag_nx] = inexact;
		end
	end

	assign ready_out = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (valid_in && ready_out) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in && ready_out) begin
			y	<= y_d;
			flags	<= flags_d;
		end
	end

endmodule

// File: verilog/fpu_div_top.sv
`timescale 1ns/1ns
`include "fpu_div_settings.svh"

module fpu_div_top import fpu_div_pkg::*; (
	input	logic			clk,
	input	logic			reset,

	input	logic			in_valid,
	output	logic			in_ready,
	input	float32_word		a,
	input	float32_word		b,
	input	round_mode_t		rm,

	output	logic			out_valid,
	input	logic			out_ready,
	output	float32_word		y,
	output	logic	[flag_w-1:0]	flags
);

	// decoder to divider.
	logic				dec_valid;
	logic				dec_ready;
	logic	[`FPU_MAN_W-1:0]	dec_man_a;
	logic	[`FPU_EXP_W-1:0]	dec_exp_a;
	logic				dec_sgn_a;
	logic				dec_zero_a;
	logic				dec_inf_a;
	logic				dec_snan_a;
	logic				dec_qnan_a;
	logic	[`FPU_MAN_W-1:0]	dec_man_b;
	logic	[`FPU_EXP_W-1:0]	dec_exp_b;
	logic				dec_sgn_b;
	logic				dec_zero_b;
	logic				dec_inf_b;
	logic				dec_snan_b;
	logic				dec_qnan_b;
	round_mode_t			dec_rm;

	// divider to rounder.
	logic				div_valid;
	logic				div_ready;
	logic	[`FPU_MAN_W-1:0]	div_man_y;
	logic	[`FPU_EXP_W-1:0]	div_exp_y;
	logic				div_sgn_y;
	logic				div_round;
	logic				div_sticky;
	logic				div_skip;
	logic				div_iv;
	logic				div_dz;
	round_mode_t			div_rm;

	operand_unpack u_unpack (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .a(a), .b(b), .rm(rm),
		.out_valid(dec_valid), .out_ready(dec_ready),
		.man_a(dec_man_a), .exp_a(dec_exp_a), .sgn_a(dec_sgn_a), .zero_a(dec_zero_a),
		.inf_a(dec_inf_a), .snan_a(dec_snan_a), .qnan_a(dec_qnan_a),
		.man_b(dec_man_b), .exp_b(dec_exp_b), .sgn_b(dec_sgn_b), .zero_b(dec_zero_b),
		.inf_b(dec_inf_b), .snan_b(dec_snan_b), .qnan_b(dec_qnan_b),
		.rm_out(dec_rm)
	);

	float_divider u_divider (
		.clk(clk), .reset(reset),
		.valid_in(dec_valid), .ready_out(dec_ready),
		.valid_out(div_valid), .ready_in(div_ready), .rm(dec_rm),
		.man_a(dec_man_a), .exp_a(dec_exp_a), .sgn_a(dec_sgn_a), .zero_a(dec_zero_a),
		.inf_a(dec_inf_a), .snan_a(dec_snan_a), .qnan_a(dec_qnan_a),
		.man_b(dec_man_b), .exp_b(dec_exp_b), .sgn_b(dec_sgn_b), .zero_b(dec_zero_b),
		.inf_b(dec_inf_b), .snan_b(dec_snan_b), .qnan_b(dec_qnan_b),
		.man_y(div_man_y), .exp_y(div_exp_y), .sgn_y(div_sgn_y),
		.round_bit(div_round), .sticky_bit(div_sticky), .skip_round(div_skip),
		.iv(div_iv), .dz(div_dz), .rm_out(div_rm)
	);

	round_pack u_round (
		.clk(clk), .reset(reset),
		.valid_in(div_valid), .ready_out(div_ready),
		.man_y(div_man_y), .exp_y(div_exp_y), .sgn_y(div_sgn_y),
		.round_bit(div_round), .sticky_bit(div_sticky), .skip_round(div_skip),
		.iv(div_iv), .dz(div_dz), .rm(div_rm),
		.out_valid(out_valid), .out_ready(out_ready), .y(y), .flags(flags)
	);

endmodule

// File: verif/fpu_div_assertions.sv
`timescale 1ns/1ns

module fpu_div_assertions import fpu_div_pkg::*; (
	input	logic			clk,
	input	logic			reset,
	input	logic			in_valid,
	input	logic			in_ready,
	input	float32_word		a,
	input	float32_word		b,
	input	logic			out_valid,
	input	logic			out_ready,
	input	float32_word		y,
	input	logic	[flag_w-1:0]	flags
);

	// a stalled request keeps its operands.
	property input_held;
		@(posedge clk) disable iff (reset)
			in_valid && !in_ready |=> in_valid && $stable(a.bits) && $stable(b.bits);
	endproperty

	property output_held;
		@(posedge clk) disable iff (reset)
			out_valid && !out_ready |=> out_valid && $stable(y.bits) && $stable(flags);
	endproperty

	property idle_after_reset;
		@(posedge clk) reset |=> !out_valid;
	endproperty

	assert property (input_held) else $error("request changed while stalled");
	assert property (output_held) else $error("result changed while stalled");
	assert property (idle_after_reset) else $error("out_valid high after reset");

endmodule

bind fpu_div_top fpu_div_assertions u_assertions (
	.clk(clk), .reset(reset),
	.in_valid(in_valid), .in_ready(in_ready), .a(a), .b(b),
	.out_valid(out_valid), .out_ready(out_ready), .y(y), .flags(flags)
);

// File: verif/fpu_div_tb.sv
`timescale 1ns/1ns

module fpu_div_tb import fpu_div_pkg::*; ();

	typedef struct packed {
		logic	[31:0]	a;
		logic	[31:0]	b;
		round_mode_t	rm;
		logic	[31:0]	y;
		logic	[4:0]	flags;	// {nv, dz, of, uf, nx}.
	} vec_t;

	localparam int n_vec = 28;
	localparam int wait_limit = 200;

	logic			clk = 1'b0;
	logic			reset;
	logic			in_valid;
	logic			in_ready;
	float32_word		a;
	float32_word		b;
	round_mode_t		rm;
	logic			out_valid;
	logic			out_ready;
	float32_word		y;
	logic	[flag_w-1:0]	flags;

	vec_t	vecs [n_vec];
	int	seed;
	int	errors;
	int	checks;
	logic	timed_out;

	fpu_div_top u_fpu_div_top (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .a(a), .b(b), .rm(rm),
		.out_valid(out_valid), .out_ready(out_ready), .y(y), .flags(flags)
	);

	always #5 clk = ~clk;

	// holds the request until the DUT takes it.
	task automatic send_row(input int i);
		int waited;
		waited = 0;
		in_valid <= 1'b1;
		a.bits <= vecs[i].a;
		b.bits <= vecs[i].b;
		rm <= vecs[i].rm;
		while (!timed_out) begin
			@(negedge clk);
			if (in_ready)
				break;
			waited++;
			if (waited == wait_limit) begin
				$display("timeout: row %0d was never accepted by the DUT", i);
				timed_out = 1'b1;
				errors++;
			end
		end
		@(posedge clk);
	endtask

	task automatic drive_all();
		for (int i = 0; i < n_vec && !timed_out; i++)
			send_row(i);
		in_valid <= 1'b0;
	endtask

	task automatic check_row(input string phase, input int i);
		logic ok;
		ok = 1'b1;
		checks++;
		assert (y.bits == vecs[i].y) else begin
			$display("mismatch at %0t: %s row %0d y %h, expected %h",
				$time, phase, i, y.bits, vecs[i].y);
			ok = 1'b0;
		end
		assert (flags == vecs[i].flags) else begin
			$display("mismatch at %0t: %s row %0d flags %b, expected %b",
				$time, phase, i, flags, vecs[i].flags);
			ok = 1'b0;
		end
		if (!ok)
			errors++;
		$display("%s row %0d: %s", phase, i, ok ? "ok" : "wrong");
	endtask

	// results must come back once each and in table order.
	task automatic collect_all(input string phase, input logic stall);
		int i;
		int waited;
		i = 0;
		waited = 0;
		while (i < n_vec && !timed_out) begin
			@(posedge clk);
			out_ready <= stall ? (($random(seed) & 3) != 0) : 1'b1;
			@(negedge clk);
			if (out_valid && out_ready) begin
				check_row(phase, i);
				i++;
				waited = 0;
			end else begin
				waited++;
				if (waited == wait_limit) begin
					$display("timeout: no result for %s row %0d", phase, i);
					timed_out = 1'b1;
					errors++;
				end
			end
		end
	endtask

	task automatic run_phase(input string phase, input logic stall);
		@(posedge clk);
		fork
			drive_all();
			collect_all(phase, stall);
		join
	endtask

	initial begin
		seed = 30711;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		a.bits = '0;
		b.bits = '0;
		rm = rne;
		out_ready = 1'b0;
		vecs = '{
			'{32'h40c00000, 32'h40400000, rne, 32'h40000000, 5'b00000},	// 6/3.
			'{32'h3f800000, 32'h40800000, rne, 32'h3e800000, 5'b00000},
			'{32'hc1100000, 32'h40400000, rtz, 32'hc0400000, 5'b00000},	// -9/3.
			'{32'h3f800000, 32'h40400000, rne, 32'h3eaaaaab, 5'b00001},	// 1/3.
			'{32'h3f800000, 32'h40400000, rtz, 32'h3eaaaaaa, 5'b00001},
			'{32'h3f800000, 32'h40400000, rdn, 32'h3eaaaaaa, 5'b00001},
			'{32'h3f800000, 32'h40400000, rup, 32'h3eaaaaab, 5'b00001},
			'{32'h3f800000, 32'h40400000, rmm, 32'h3eaaaaab, 5'b00001},
			'{32'h40000000, 32'h40400000, rne, 32'h3f2aaaab, 5'b00001},	// 2/3.
			'{32'h40000000, 32'h40400000, rtz, 32'h3f2aaaaa, 5'b00001},
			'{32'h40000000, 32'h40400000, rdn, 32'h3f2aaaaa, 5'b00001},
			'{32'h40000000, 32'h40400000, rup, 32'h3f2aaaab, 5'b00001},
			'{32'h40000000, 32'h40400000, rmm, 32'h3f2aaaab, 5'b00001},
			'{32'h7f800001, 32'h3f800000, rne, 32'h7fc00000, 5'b10000},	// snan.
			'{32'h7fc00000, 32'h3f800000, rne, 32'h7fc00000, 5'b00000},	// qnan.
			'{32'h00000000, 32'h00000000, rne, 32'h7fc00000, 5'b10000},
			'{32'h7f800000, 32'hff800000, rne, 32'h7fc00000, 5'b10000},
			'{32'h3f800000, 32'h80000000, rne, 32'hff800000, 5'b01000},	// 1/-0.
			'{32'h80000000, 32'h40400000, rne, 32'h80000000, 5'b00000},
			'{32'h40a00000, 32'hff800000, rne, 32'h80000000, 5'b00000},
			'{32'h00000001, 32'h3f800000, rne, 32'h00000000, 5'b00000},	// subnormal.
			'{32'h7f7fffff, 32'h3f000000, rne, 32'h7f800000, 5'b00101},	// max/0.5.
			'{32'h7f7fffff, 32'h3f000000, rtz, 32'h7f7fffff, 5'b00101},
			'{32'h7f7fffff, 32'h3f000000, rdn, 32'h7f7fffff, 5'b00101},
			'{32'hff7fffff, 32'h3f000000, rup, 32'hff7fffff, 5'b00101},
			'{32'hff7fffff, 32'h3f000000, rdn, 32'hff800000, 5'b00101},
			'{32'h00800000, 32'h40800000, rne, 32'h00000000, 5'b00011},	// min/4.
			'{32'h80800000, 32'h40800000, rdn, 32'h80000000, 5'b00011}
		};
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		run_phase("steady", 1'b0);
		if (!timed_out)
			run_phase("stalled", 1'b1);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: build.f
+incdir+verilog
verilog/fpu_div_pkg.sv
verilog/operand_unpack.sv
verilog/float_divider.sv
verilog/round_pack.sv
verilog/fpu_div_top.sv
verif/fpu_div_assertions.sv
verif/fpu_div_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module fpu_div_tb

out=$(./obj_dir/Vfpu_div_tb) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1
